// File: hw/nn_arith_pkg.sv
package nn_arith_pkg;

    // Datapath word, sums wrap modulo 2^16
    localparam int unsigned WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // Fixed point with 1.0 at 1024
    localparam word_t FIX_ONE  = 16'd1024;
    localparam word_t FIX_HALF = 16'd512;

    // Upper bounds of the sigmoid segments, unsigned compare
    localparam word_t SEG1_LIMIT = 16'd1024;
    localparam word_t SEG2_LIMIT = 16'd2432;
    localparam word_t SEG3_LIMIT = 16'd5120;

    // Offset added after the shift in each segment
    localparam word_t SEG1_OFFS = 16'd512;
    localparam word_t SEG2_OFFS = 16'd640;
    localparam word_t SEG3_OFFS = 16'd864;

    // Slope of each segment as a right shift
    localparam int unsigned SEG1_SHIFT = 2;
    localparam int unsigned SEG2_SHIFT = 3;
    localparam int unsigned SEG3_SHIFT = 5;

    // Sigmoid segment select
    typedef enum logic [1:0] {
        SEG_LOW,
        SEG_MID,
        SEG_HIGH,
        SEG_SAT
    } sig_seg_e;

endpackage

// File: hw/nn_weights_pkg.sv
package nn_weights_pkg;

    // Layer widths
    localparam int unsigned N_IN  = 2;
    localparam int unsigned N_L1  = 8;
    localparam int unsigned N_L2  = 12;
    localparam int unsigned N_L3  = 6;
    localparam int unsigned N_L4  = 4;
    localparam int unsigned N_OUT = 1;

    // Weight signs, bit [o*n_in + i] set means input i enters neuron o as ~x
    // Literals list the last neuron first, and inside a neuron the last input first

    localparam logic [N_L1*N_IN-1:0] NEG_L1 = {
        2'b01, 2'b01, 2'b11, 2'b01,
        2'b01, 2'b10, 2'b11, 2'b11
    };

    localparam logic [N_L2*N_L1-1:0] NEG_L2 = {
        8'b0001_1000, 8'b0011_0110, 8'b1101_0000, 8'b0011_0000,
        8'b0000_0111, 8'b0110_1101, 8'b0111_0001, 8'b1101_0000,
        8'b0000_1110, 8'b1101_1010, 8'b0010_1110, 8'b1001_1010
    };

    localparam logic [N_L3*N_L2-1:0] NEG_L3 = {
        12'b0011_0011_0011,
        12'b0000_1000_0111,
        12'b1110_0010_0010,
        12'b1010_0110_1101,
        12'b0000_1101_1001,
        12'b0000_1101_1011
    };

    // First two neurons take every input negated
    localparam logic [N_L4*N_L3-1:0] NEG_L4 = {
        6'b10_1100,
        6'b10_1100,
        6'b11_1111,
        6'b11_1111
    };

    // Output neuron is a plain sum
    localparam logic [N_OUT*N_L4-1:0] NEG_OUT = '0;

endpackage

// File: hw/dense_layer.sv
`timescale 1ns/10ps

module dense_layer
    import nn_arith_pkg::*;
#(
    parameter int unsigned                  N_IN_P     = 2,
    parameter int unsigned                  N_OUT_P    = 8,
    parameter logic [N_IN_P*N_OUT_P-1:0]    NEG_MASK_P = '0,
    parameter bit                           USE_RELU_P = 1'b1
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  word_t   act_i [N_IN_P],
    output word_t   act_o [N_OUT_P]
);

    for (genvar o = 0; o < N_OUT_P; o++)
    begin : g_neuron
        word_t sum_c;
        word_t act_c;
        word_t act_q;

        // Sign-only weights, a negative weight is a bitwise complement
        always_comb
        begin
            sum_c = '0;
            for (int i = 0; i < N_IN_P; i++)
            begin
                sum_c = sum_c + (NEG_MASK_P[o*N_IN_P + i] ? ~act_i[i] : act_i[i]);
            end
        end

        // ReLU clears anything with the sign bit set
        assign act_c = (USE_RELU_P && sum_c[WORD_W-1]) ? '0 : sum_c;

        always_ff @(posedge clk or negedge rst_n_i)
        begin
            if (!rst_n_i)
            begin
                act_q <= '0;
            end
            else
            begin
                act_q <= act_c;
            end
        end

        assign act_o[o] = act_q;

        // A rectified neuron never presents a negative word downstream
        if (USE_RELU_P)
        begin : g_relu_chk
            a_relu_nonneg : assert property (
                @(posedge clk) disable iff (!rst_n_i)
                !act_o[o][WORD_W-1]
            );
        end
    end

endmodule

// File: hw/sigmoid_classify.sv
`timescale 1ns/10ps

module sigmoid_classify
    import nn_arith_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  word_t   sum_i,
    output word_t   sig_o,
    output logic    class_o
);

    sig_seg_e seg_c;
    word_t    sig_c;
    word_t    sig_q;

    // Segment select, sum treated as unsigned so negatives saturate
    always_comb
    begin
        if (sum_i < SEG1_LIMIT)
        begin
            seg_c = SEG_LOW;
        end
        else if (sum_i < SEG2_LIMIT)
        begin
            seg_c = SEG_MID;
        end
        else if (sum_i < SEG3_LIMIT)
        begin
            seg_c = SEG_HIGH;
        end
        else
        begin
            seg_c = SEG_SAT;
        end
    end

    // Piecewise linear approximation
    always_comb
    begin
        case (seg_c)
            SEG_LOW:  sig_c = (sum_i >> SEG1_SHIFT) + SEG1_OFFS;
            SEG_MID:  sig_c = (sum_i >> SEG2_SHIFT) + SEG2_OFFS;
            SEG_HIGH: sig_c = (sum_i >> SEG3_SHIFT) + SEG3_OFFS;
            default:  sig_c = FIX_ONE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            sig_q <= '0;
        end
        else
        begin
            sig_q <= sig_c;
        end
    end

    assign sig_o = sig_q;

    // Decision threshold at one half
    assign class_o = (sig_q > FIX_HALF);

    // Once the first sample has been loaded the output stays within [0.5, 1.0]
    a_sig_range : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (sig_o >= FIX_HALF) && (sig_o <= FIX_ONE)
    );

    // Only sums too small to move the low segment off one half give class 0
    a_class_thr : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        1'b1 |=> class_o == $past((sum_i >> SEG1_SHIFT) != '0)
    );

endmodule

// File: hw/sleep_classifier.sv
`timescale 1ns/10ps

module sleep_classifier
    import nn_arith_pkg::*;
    import nn_weights_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  word_t   x1_i,
    input  word_t   x2_i,
    output word_t   sig_o,
    output logic    class_o
);

    word_t in_w  [N_IN];
    word_t l1_w  [N_L1];
    word_t l2_w  [N_L2];
    word_t l3_w  [N_L3];
    word_t l4_w  [N_L4];
    word_t out_w [N_OUT];

    assign in_w[0] = x1_i;
    assign in_w[1] = x2_i;

    // Hidden layers, all rectified
    dense_layer #(
        .N_IN_P     (N_IN),
        .N_OUT_P    (N_L1),
        .NEG_MASK_P (NEG_L1),
        .USE_RELU_P (1'b1)
    ) u_l1 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (in_w),
        .act_o   (l1_w)
    );

    dense_layer #(
        .N_IN_P     (N_L1),
        .N_OUT_P    (N_L2),
        .NEG_MASK_P (NEG_L2),
        .USE_RELU_P (1'b1)
    ) u_l2 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (l1_w),
        .act_o   (l2_w)
    );

    dense_layer #(
        .N_IN_P     (N_L2),
        .N_OUT_P    (N_L3),
        .NEG_MASK_P (NEG_L3),
        .USE_RELU_P (1'b1)
    ) u_l3 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (l2_w),
        .act_o   (l3_w)
    );

    dense_layer #(
        .N_IN_P     (N_L3),
        .N_OUT_P    (N_L4),
        .NEG_MASK_P (NEG_L4),
        .USE_RELU_P (1'b1)
    ) u_l4 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (l3_w),
        .act_o   (l4_w)
    );

    // Output neuron keeps its raw sum for the sigmoid
    dense_layer #(
        .N_IN_P     (N_L4),
        .N_OUT_P    (N_OUT),
        .NEG_MASK_P (NEG_OUT),
        .USE_RELU_P (1'b0)
    ) u_out (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .act_i   (l4_w),
        .act_o   (out_w)
    );

    sigmoid_classify u_sig (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .sum_i   (out_w[0]),
        .sig_o   (sig_o),
        .class_o (class_o)
    );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen
(
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 5;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

    // Reset held low over the first rising edges
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: test/tb_sleep_classifier.sv
`timescale 1ns/10ps

module tb_sleep_classifier
    import nn_arith_pkg::*;
    import nn_weights_pkg::*;
();

    localparam int LATENCY     = 6;
    localparam int MAX_CYCLES  = 2000;
    localparam int RST_TIMEOUT = 20;
    localparam int N_RANDOM    = 200;
    localparam int SCAN_MAX    = 4095;
    localparam int MAX_W       = 12;
    localparam int MASK_W      = N_L2 * N_L1;

    typedef word_t vec_t [MAX_W];

    logic   clk;
    logic   rst_n;
    word_t  x1;
    word_t  x2;
    word_t  sig;
    logic   cls;

    integer seed;
    int     err_word;
    int     err_class;
    int     err_seg;
    int     err_other;
    int     seg_hits [4];

    // Expected results in the order the samples enter the pipeline
    word_t    exp_sig_q [$];
    logic     exp_cls_q [$];
    sig_seg_e exp_seg_q [$];

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    sleep_classifier UUT (
        .clk     (clk),
        .rst_n_i (rst_n),
        .x1_i    (x1),
        .x2_i    (x2),
        .sig_o   (sig),
        .class_o (cls)
    );

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp)
        begin
            err_word++;
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, act, exp);
        end
    endtask

    task automatic check_class(input logic act, input logic exp);
        if (act !== exp)
        begin
            err_class++;
            $display("[ERROR] class_o: got 0x%0h, expected 0x%0h", act, exp);
        end
    endtask

    task automatic check_seg(input sig_seg_e act, input sig_seg_e exp);
        if (act !== exp)
        begin
            err_seg++;
            $display("[ERROR] sigmoid segment: got 0x%0h, expected 0x%0h", act, exp);
        end
    endtask

    // One layer of sign-only neurons, a weight of -1 subtracts v and one more
    task automatic layer_model(input vec_t act_in, input int n_in, input int n_out,
                               input logic [MASK_W-1:0] neg, input bit relu,
                               output vec_t act_out);
        word_t acc;
        act_out = '{default: '0};
        for (int o = 0; o < n_out; o++)
        begin
            acc = '0;
            for (int i = 0; i < n_in; i++)
            begin
                if (neg[o*n_in + i])
                begin
                    acc = acc - act_in[i] - 16'd1;
                end
                else
                begin
                    acc = acc + act_in[i];
                end
            end
            if (relu && acc[WORD_W-1])
            begin
                acc = '0;
            end
            act_out[o] = acc;
        end
    endtask

    task automatic net_model(input word_t a, input word_t b, output word_t sum);
        vec_t v0;
        vec_t v1;
        v0 = '{default: '0};
        v0[0] = a;
        v0[1] = b;
        layer_model(v0, N_IN, N_L1, MASK_W'(NEG_L1), 1'b1, v1);
        layer_model(v1, N_L1, N_L2, MASK_W'(NEG_L2), 1'b1, v0);
        layer_model(v0, N_L2, N_L3, MASK_W'(NEG_L3), 1'b1, v1);
        layer_model(v1, N_L3, N_L4, MASK_W'(NEG_L4), 1'b1, v0);
        layer_model(v0, N_L4, N_OUT, MASK_W'(NEG_OUT), 1'b0, v1);
        sum = v1[0];
    endtask

    function automatic sig_seg_e seg_model(input word_t s);
        if (s < SEG1_LIMIT)
        begin
            return SEG_LOW;
        end
        if (s < SEG2_LIMIT)
        begin
            return SEG_MID;
        end
        if (s < SEG3_LIMIT)
        begin
            return SEG_HIGH;
        end
        return SEG_SAT;
    endfunction

    function automatic word_t sig_model(input word_t s);
        case (seg_model(s))
            SEG_LOW:  return s / 16'd4 + SEG1_OFFS;
            SEG_MID:  return s / 16'd8 + SEG2_OFFS;
            SEG_HIGH: return s / 16'd32 + SEG3_OFFS;
            default:  return FIX_ONE;
        endcase
    endfunction

    task automatic push_expected(input word_t a, input word_t b);
        word_t sum;
        word_t s;
        net_model(a, b, sum);
        s = sig_model(sum);
        exp_sig_q.push_back(s);
        exp_cls_q.push_back(s > FIX_HALF);
        exp_seg_q.push_back(seg_model(sum));
    endtask

    // New sample on the rising edge, outputs compared on the falling edge
    task automatic drive_cycle(input word_t a, input word_t b);
        @(posedge clk);
        x1 <= a;
        x2 <= b;
        push_expected(a, b);
        @(negedge clk);
        if (exp_sig_q.size() > LATENCY)
        begin
            check_word("sig_o", sig, exp_sig_q.pop_front());
            check_class(cls, exp_cls_q.pop_front());
            void'(exp_seg_q.pop_front());
            // Segment select sees the sample that reaches sig_o on the next edge
            check_seg(UUT.u_sig.seg_c, exp_seg_q[0]);
        end
    endtask

    task automatic drain_pipeline;
        repeat (LATENCY) drive_cycle('0, '0);
    endtask

    task automatic wait_reset_release;
        int waited;
        waited = 0;
        while (rst_n !== 1'b1 && waited < RST_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1)
        begin
            err_other++;
            $display("Reset was not released within %0d cycles", RST_TIMEOUT);
        end
    endtask

    task automatic test_reset;
        @(negedge clk);
        if (rst_n !== 1'b0)
        begin
            err_other++;
            $display("Reset was not active at the start of the run");
        end
        check_word("sig_o", sig, '0);
        check_class(cls, 1'b0);
        wait_reset_release();
        check_word("sig_o", sig, '0);
        check_class(cls, 1'b0);
        // Cleared stages hold the zero-input response
        repeat (LATENCY) push_expected('0, '0);
        repeat (LATENCY) drive_cycle('0, '0);
        check_word("sig_o", sig, FIX_HALF);
        check_class(cls, 1'b0);
    endtask

    task automatic test_single_sample;
        repeat (2) drive_cycle('0, '0);
        drive_cycle(16'd200, 16'd40);
        drain_pipeline();
    endtask

    task automatic test_pipeline;
        for (int k = 0; k < 8; k++)
        begin
            drive_cycle(word_t'(60 + 97 * k), word_t'(13 * k));
        end
        drain_pipeline();
    endtask

    // Nearest output sums on each side of a boundary, with x2 held at zero
    task automatic bracket_limit(input word_t limit, output word_t below_x,
                                 output bit found_below, output word_t above_x,
                                 output bit found_above);
        word_t sum;
        word_t best_below;
        word_t best_above;
        found_below = 1'b0;
        found_above = 1'b0;
        below_x     = '0;
        above_x     = '0;
        best_below  = '0;
        best_above  = '1;
        for (int x = 0; x <= SCAN_MAX; x++)
        begin
            net_model(word_t'(x), '0, sum);
            if (sum < limit && (!found_below || sum > best_below))
            begin
                best_below  = sum;
                below_x     = word_t'(x);
                found_below = 1'b1;
            end
            else if (sum >= limit && (!found_above || sum < best_above))
            begin
                best_above  = sum;
                above_x     = word_t'(x);
                found_above = 1'b1;
            end
        end
    endtask

    task automatic test_segments;
        word_t limits [4];
        word_t below_x;
        word_t above_x;
        word_t sum;
        bit    found_below;
        bit    found_above;
        limits   = '{SEG1_LIMIT, SEG2_LIMIT, SEG3_LIMIT, 16'h8000};
        seg_hits = '{default: 0};
        for (int k = 0; k < 4; k++)
        begin
            bracket_limit(limits[k], below_x, found_below, above_x, found_above);
            if (!found_below || !found_above)
            begin
                err_other++;
                $display("No input pair found on both sides of sum 0x%04h", limits[k]);
            end
            else
            begin
                net_model(below_x, '0, sum);
                seg_hits[seg_model(sum)]++;
                net_model(above_x, '0, sum);
                seg_hits[seg_model(sum)]++;
                drive_cycle(below_x, '0);
                drive_cycle(above_x, '0);
            end
        end
        drain_pipeline();
        for (int s = 0; s < 4; s++)
        begin
            if (seg_hits[s] == 0)
            begin
                err_other++;
                $display("Sigmoid segment %0d was never reached", s);
            end
        end
    endtask

    task automatic test_random;
        word_t a;
        word_t b;
        for (int k = 0; k < N_RANDOM; k++)
        begin
            a = word_t'($random(seed));
            b = word_t'($random(seed));
            // Small operands on every other pair reach the lower segments
            if (k % 2 == 1)
            begin
                a = a & 16'h0fff;
                b = b & 16'h00ff;
            end
            drive_cycle(a, b);
        end
        drain_pipeline();
    endtask

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        x1        = '0;
        x2        = '0;
        seed      = 32'hdaaa_a128;
        err_word  = 0;
        err_class = 0;
        err_seg   = 0;
        err_other = 0;

        test_reset();
        if (err_other == 0)
        begin
            test_single_sample();
            test_pipeline();
            test_segments();
            test_random();
        end

        $display("Error counts: sig_o %0d, class_o %0d, segment %0d, other %0d",
                 err_word, err_class, err_seg, err_other);
        if (err_word + err_class + err_seg + err_other == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/nn_arith_pkg.sv
hw/nn_weights_pkg.sv
hw/dense_layer.sv
hw/sigmoid_classify.sv
hw/sleep_classifier.sv
test/tb_clk_gen.sv
test/tb_sleep_classifier.sv

// File: Makefile
# Verilator build and run of the sleep classifier testbench

VERILATOR ?= verilator
TOP       ?= tb_sleep_classifier
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
